/* Bender.yml */
package:
  name: streaming_sha256

sources:
  - sha256_pkg.sv
  - byte_input_fifo.sv
  - sha256_message_schedule.sv
  - sha256_core.sv
  - streaming_sha256.sv
  - target: test
    files:
      - sha256_props.sv
      - tb_streaming_sha256.sv

/* byte_input_fifo.sv */
`timescale 1ns/1ps

module byte_input_fifo #(
	parameter int FIFO_DEPTH = 128
) (
	input logic clk,
	input logic reset,
	input logic wr,
	input sha256_pkg::sha256_word_t din,
	input logic [2:0] bytes_valid,
	input logic flush,
	input logic rd,
	output sha256_pkg::sha256_word_t dout,
	output logic [31:0] rsize,
	output logic overflow
);

	// Depth must be a power of two, pointers wrap naturally
	localparam int ADDR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = ADDR_W + 1;

	logic [7:0] mem [FIFO_DEPTH];
	logic [ADDR_W-1:0] wptr;
	logic [ADDR_W-1:0] rptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	// Set by flush until the tail has been read out
	logic flushed;

	// Bytes written and read this cycle
	logic [2:0] wr_n;
	logic [2:0] rd_n;

	sha256_pkg::sha256_word_u din_u;
	sha256_pkg::sha256_word_u rd_word;

	////////////////////
	// Write side

	always_comb begin
		din_u.word = din;
	end

	// A write that does not fit is dropped whole
	assign overflow = wr && ((int'(count) + int'(bytes_valid)) > FIFO_DEPTH);
	assign wr_n = (wr && !overflow) ? bytes_valid : 3'd0;

	// Valid bytes are left-justified, byte 0 goes in first
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (i < wr_n) begin
				mem[wptr + ADDR_W'(i)] <= din_u.bytes[i];
			end
		end
	end

	////////////////////
	// Read side

	// Full word if there is one, else the flushed tail
	always_comb begin
		if (!rd) begin
			rd_n = 3'd0;
		end else if (count >= CNT_W'(4)) begin
			rd_n = 3'd4;
		end else if (flushed) begin
			rd_n = count[2:0];
		end else begin
			rd_n = 3'd0;
		end
	end

	// Bytes past the read count come out as zero
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (i < rd_n) begin
				rd_word.bytes[i] = mem[rptr + ADDR_W'(i)];
			end else begin
				rd_word.bytes[i] = 8'h00;
			end
		end
	end

	// Registered output, valid the cycle after rd
	always_ff @(posedge clk) begin
		if (rd) begin
			dout <= rd_word.word;
		end
	end

	////////////////////
	// Pointers and level

	assign count_next = count + CNT_W'(wr_n) - CNT_W'(rd_n);
	assign rsize = 32'(count);

	always_ff @(posedge clk) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
			flushed <= 1'b0;
		end else begin
			wptr <= wptr + ADDR_W'(wr_n);
			rptr <= rptr + ADDR_W'(rd_n);
			count <= count_next;

			// Tail mark lasts until the FIFO drains
			if (flush) begin
				flushed <= 1'b1;
			end else if (count_next == '0) begin
				flushed <= 1'b0;
			end
		end
	end

endmodule

/* filelist.f */
sha256_pkg.sv
byte_input_fifo.sv
sha256_message_schedule.sv
sha256_core.sv
streaming_sha256.sv
sha256_props.sv
tb_streaming_sha256.sv

/* sha256_core.sv */
`timescale 1ns/1ps

module sha256_core (
	input logic clk,
	input logic reset,
	input logic start,
	input logic update,
	input logic [2:0] bytes_valid,
	input logic finalize,
	input sha256_pkg::sha256_word_t fifo_dout,
	input logic [31:0] fifo_rsize,
	input sha256_pkg::sha256_word_t w0,
	input sha256_pkg::sha256_word_t w1,
	output logic fifo_rd,
	output logic w_load,
	output logic [3:0] w_index,
	output sha256_pkg::sha256_word_t w_word,
	output logic w_zero_fill,
	output logic w_pad,
	output logic [5:0] pad_pos,
	output logic w_length,
	output logic [63:0] length_bits,
	output logic w_step,
	output logic extend,
	output logic hash_valid,
	output sha256_pkg::sha256_digest_t hash
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_READ_PIPE = 3'd1;
	localparam logic [2:0] ST_FILL_W = 3'd2;
	localparam logic [2:0] ST_PAD = 3'd3;
	localparam logic [2:0] ST_PRECOMPUTE = 3'd4;
	localparam logic [2:0] ST_COMPRESS = 3'd5;
	localparam logic [2:0] ST_BLOCK_DONE = 3'd6;
	localparam logic [2:0] ST_DONE = 3'd7;

	logic [2:0] state;
	logic start_pending;
	logic finalizing;
	logic last_block;
	// 0x80 already placed in an earlier block
	logic marker_done;
	// Read issued last cycle, FIFO word valid now
	logic rd_q;

	logic [31:0] msg_len;
	logic [31:0] len_final;
	logic [31:0] bytes_moved;
	// Words requested and words loaded in this block
	logic [4:0] rd_count;
	logic [4:0] wr_count;
	logic [5:0] round;

	logic gather;
	logic data_done;
	logic place_marker;
	logic place_length;

	// Working registers, chaining value and h + k + w one round ahead
	sha256_pkg::sha256_word_t a, b, c, d, e, f, g, h;
	sha256_pkg::sha256_word_t hkw;
	sha256_pkg::sha256_word_t temp1;
	sha256_pkg::sha256_word_t temp2;
	sha256_pkg::sha256_digest_t chain;
	sha256_pkg::sha256_digest_t work;

	function automatic sha256_pkg::sha256_word_t big_sigma0(input sha256_pkg::sha256_word_t x);
		return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
	endfunction

	function automatic sha256_pkg::sha256_word_t big_sigma1(input sha256_pkg::sha256_word_t x);
		return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
	endfunction

	////////////////////
	// Message length

	always_ff @(posedge clk) begin
		if (reset) begin
			msg_len <= '0;
		end else if (start) begin
			msg_len <= '0;
		end else if (update) begin
			msg_len <= msg_len + 32'(bytes_valid);
		end
	end

	////////////////////
	// Block gathering and padding decisions

	// Pull words while idle and not starting over
	assign gather = (state == ST_IDLE) && !start && !start_pending;

	// Partial words only once the tail is flushed
	assign fifo_rd = gather && (rd_count < 5'd16) &&
		((fifo_rsize >= 32'd4) || (finalizing && (fifo_rsize != '0)));

	assign data_done = finalizing && (bytes_moved >= len_final);

	// A full block ending exactly on the message end gets its marker next block
	assign place_marker = data_done && !marker_done &&
		!(wr_count[4] && (len_final[5:0] == 6'd0));

	// Length fits after the marker only up to byte 55
	assign place_length = data_done &&
		(marker_done || (place_marker && (len_final[5:0] <= 6'd55)));

	// Schedule controls
	assign w_load = rd_q;
	assign w_index = wr_count[3:0];
	assign w_word = fifo_dout;
	assign w_zero_fill = (state == ST_FILL_W) && !wr_count[4];
	assign w_pad = (state == ST_PAD) && place_marker;
	assign pad_pos = len_final[5:0];
	assign w_length = (state == ST_PAD) && place_length;
	assign length_bits = {29'd0, len_final, 3'd0};
	assign w_step = (state == ST_COMPRESS);
	assign extend = w_step && (round < 6'(sha256_pkg::ROUNDS - 16));

	////////////////////
	// Round function

	assign temp1 = big_sigma1(e) + ((e & f) ^ (~e & g)) + hkw;
	assign temp2 = big_sigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
	assign work = {a, b, c, d, e, f, g, h};

	////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			start_pending <= 1'b0;
			finalizing <= 1'b0;
			last_block <= 1'b0;
			marker_done <= 1'b0;
			rd_q <= 1'b0;
			len_final <= '0;
			bytes_moved <= '0;
			rd_count <= '0;
			wr_count <= '0;
			round <= '0;
			hash_valid <= 1'b0;
			hash <= '0;
		end else begin
			hash_valid <= 1'b0;
			rd_q <= fifo_rd;

			// Start during a block waits for idle
			if (start && (state != ST_IDLE)) begin
				start_pending <= 1'b1;
			end

			// Length is final once the host flushes
			if (finalize) begin
				finalizing <= 1'b1;
				len_final <= msg_len;
			end

			if (fifo_rd) begin
				rd_count <= rd_count + 5'd1;
				bytes_moved <= bytes_moved + 32'd4;
			end
			if (rd_q) begin
				wr_count <= wr_count + 5'd1;
			end

			case (state)
				ST_IDLE: begin
					if (start || start_pending) begin
						start_pending <= 1'b0;
						marker_done <= 1'b0;
						bytes_moved <= '0;
						rd_count <= '0;
						wr_count <= '0;
					end else if ((fifo_rd && (rd_count == 5'd15)) || (data_done && !fifo_rd)) begin
						state <= ST_READ_PIPE;
					end
				end

				// Last FIFO word lands here
				ST_READ_PIPE: begin
					state <= ST_FILL_W;
				end

				ST_FILL_W: begin
					last_block <= place_length;
					if (place_marker || place_length) begin
						state <= ST_PAD;
					end else begin
						state <= ST_PRECOMPUTE;
					end
				end

				ST_PAD: begin
					if (place_marker) begin
						marker_done <= 1'b1;
					end
					state <= ST_PRECOMPUTE;
				end

				ST_PRECOMPUTE: begin
					round <= '0;
					rd_count <= '0;
					wr_count <= '0;
					state <= ST_COMPRESS;
				end

				ST_COMPRESS: begin
					round <= round + 6'd1;
					if (round == 6'(sha256_pkg::ROUNDS - 1)) begin
						state <= ST_BLOCK_DONE;
					end
				end

				// Not last means more data or the length-only block
				ST_BLOCK_DONE: begin
					state <= last_block ? ST_DONE : ST_IDLE;
				end

				ST_DONE: begin
					hash_valid <= 1'b1;
					hash <= chain;
					finalizing <= 1'b0;
					marker_done <= 1'b0;
					last_block <= 1'b0;
					state <= ST_IDLE;
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// Hash datapath

	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				if (start || start_pending) begin
					chain <= sha256_pkg::SHA256_H_INIT;
				end
			end

			ST_PRECOMPUTE: begin
				{a, b, c, d, e, f, g, h} <= chain;
				hkw <= chain[31:0] + sha256_pkg::sha256_k(6'd0) + w0;
			end

			ST_COMPRESS: begin
				h <= g;
				g <= f;
				f <= e;
				e <= d + temp1;
				d <= c;
				c <= b;
				b <= a;
				a <= temp1 + temp2;
				// Next round's h is today's g, its W is today's w1
				hkw <= g + sha256_pkg::sha256_k(round + 6'd1) + w1;
			end

			// Fold the block into the chaining value
			ST_BLOCK_DONE: begin
				for (int i = 0; i < 8; i++) begin
					chain[32*i +: 32] <= chain[32*i +: 32] + work[32*i +: 32];
				end
			end

			default: begin
			end
		endcase
	end

endmodule

/* sha256_message_schedule.sv */
`timescale 1ns/1ps

module sha256_message_schedule (
	input logic clk,
	input logic reset,
	input logic w_load,
	input logic [3:0] w_index,
	input sha256_pkg::sha256_word_t w_word,
	input logic w_zero_fill,
	input logic w_pad,
	input logic [5:0] pad_pos,
	input logic w_length,
	input logic [63:0] length_bits,
	input logic w_step,
	input logic extend,
	output sha256_pkg::sha256_word_t w0,
	output sha256_pkg::sha256_word_t w1
);

	// Sliding window W[t..t+15], w[0] is the current round's word
	sha256_pkg::sha256_word_u w [16];

	sha256_pkg::sha256_word_t w_ext;
	logic [3:0] pad_word;

	// sigma0: ror 7, ror 18, shr 3
	function automatic sha256_pkg::sha256_word_t small_sigma0(input sha256_pkg::sha256_word_t x);
		return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
	endfunction

	// sigma1: ror 17, ror 19, shr 10
	function automatic sha256_pkg::sha256_word_t small_sigma1(input sha256_pkg::sha256_word_t x);
		return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
	endfunction

	// W[t+16] from W[t], W[t+1], W[t+9], W[t+14]
	assign w_ext = w[0].word + small_sigma0(w[1].word) + w[9].word + small_sigma1(w[14].word);

	assign pad_word = pad_pos[5:2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				w[i] <= '0;
			end
		end else begin
			if (w_load) begin
				w[w_index].word <= w_word;
			end

			// Clear the unused tail of the block
			if (w_zero_fill) begin
				for (int i = 0; i < 16; i++) begin
					if (i >= w_index) begin
						w[i].word <= 32'h0;
					end
				end
			end

			// 0x80 marker, then zeros to the end of the word
			if (w_pad) begin
				for (int b = 0; b < 4; b++) begin
					if (b == pad_pos[1:0]) begin
						w[pad_word].bytes[b] <= 8'h80;
					end else if (b > pad_pos[1:0]) begin
						w[pad_word].bytes[b] <= 8'h00;
					end
				end
			end

			// Big-endian bit count in the last two words
			if (w_length) begin
				w[14].word <= length_bits[63:32];
				w[15].word <= length_bits[31:0];
			end

			// One round forward
			if (w_step) begin
				for (int i = 0; i < 15; i++) begin
					w[i] <= w[i + 1];
				end
				w[15].word <= extend ? w_ext : 32'h0;
			end
		end
	end

	assign w0 = w[0].word;
	assign w1 = w[1].word;

endmodule

/* sha256_pkg.sv */
package sha256_pkg;

	////////////////////
	// Basic word types

	typedef logic [31:0] sha256_word_t;

	// Digest word a sits in the top 32 bits
	typedef logic [255:0] sha256_digest_t;

	// One schedule word seen either whole or as four bytes
	// Byte 0 is the most significant (first on the wire)
	typedef union packed {
		sha256_word_t word;
		logic [0:3][7:0] bytes;
	} sha256_word_u;

	localparam int ROUNDS = 64;

	////////////////////
	// Initial chaining value H0..H7

	localparam sha256_digest_t SHA256_H_INIT = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	////////////////////
	// Round constants, k[0] leftmost

	localparam logic [0:ROUNDS-1][31:0] K_TABLE = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Lookup of k[index], index wraps at 64
	function automatic sha256_word_t sha256_k(input logic [5:0] index);
		return K_TABLE[index];
	endfunction

endpackage

/* sha256_props.sv */
`timescale 1ns/1ps

module sha256_props (
	input logic clk,
	input logic reset,
	input logic finalize,
	input logic hash_valid,
	input sha256_pkg::sha256_digest_t hash,
	input logic fifo_overflow
);

	// Count of failed assertions
	int assert_fails = 0;

	////////////////////
	// Digest strobe

	// Single-cycle pulse
	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		hash_valid |=> !hash_valid)
		else begin
			assert_fails++;
			$error("hash_valid stayed high for two cycles");
		end

	// At least one full block of rounds after the flush
	a_min_latency: assert property (@(posedge clk) disable iff (reset)
		finalize |=> !hash_valid [*sha256_pkg::ROUNDS])
		else begin
			assert_fails++;
			$error("hash_valid came too soon after finalize");
		end

	////////////////////
	// Input side and output hold

	// Host bytes beyond the FIFO depth are lost
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		!fifo_overflow)
		else begin
			assert_fails++;
			$error("input FIFO overflow");
		end

	// Digest only moves with its strobe, or when reset clears it
	a_hash_hold: assert property (@(posedge clk) disable iff (reset)
		(!hash_valid && !$past(reset)) |-> $stable(hash))
		else begin
			assert_fails++;
			$error("hash changed outside a hash_valid cycle");
		end

endmodule

bind streaming_sha256 sha256_props props (
	.clk(clk),
	.reset(reset),
	.finalize(finalize),
	.hash_valid(hash_valid),
	.hash(hash),
	.fifo_overflow(fifo_overflow)
);

/* streaming_sha256.sv */
`timescale 1ns/1ps

module streaming_sha256 #(
	parameter int FIFO_DEPTH = 128
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic update,
	input sha256_pkg::sha256_word_t data_in,
	input logic [2:0] bytes_valid,
	input logic finalize,
	output logic hash_valid,
	output sha256_pkg::sha256_digest_t hash
);

	////////////////////
	// Core to FIFO

	logic fifo_rd;
	sha256_pkg::sha256_word_t fifo_dout;
	logic [31:0] fifo_rsize;
	// Lost host bytes, watched by the assertions
	logic fifo_overflow;

	////////////////////
	// Core to schedule

	logic w_load;
	logic [3:0] w_index;
	sha256_pkg::sha256_word_t w_word;
	logic w_zero_fill;
	logic w_pad;
	logic [5:0] pad_pos;
	logic w_length;
	logic [63:0] length_bits;
	logic w_step;
	logic extend;
	sha256_pkg::sha256_word_t w0;
	sha256_pkg::sha256_word_t w1;

	// Host writes go straight in, finalize flushes the tail
	byte_input_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) in_fifo (
		.clk(clk),
		.reset(reset),
		.wr(update),
		.din(data_in),
		.bytes_valid(bytes_valid),
		.flush(finalize),
		.rd(fifo_rd),
		.dout(fifo_dout),
		.rsize(fifo_rsize),
		.overflow(fifo_overflow)
	);

	sha256_message_schedule schedule (
		.clk(clk),
		.reset(reset),
		.w_load(w_load),
		.w_index(w_index),
		.w_word(w_word),
		.w_zero_fill(w_zero_fill),
		.w_pad(w_pad),
		.pad_pos(pad_pos),
		.w_length(w_length),
		.length_bits(length_bits),
		.w_step(w_step),
		.extend(extend),
		.w0(w0),
		.w1(w1)
	);

	sha256_core core (
		.clk(clk),
		.reset(reset),
		.start(start),
		.update(update),
		.bytes_valid(bytes_valid),
		.finalize(finalize),
		.fifo_dout(fifo_dout),
		.fifo_rsize(fifo_rsize),
		.w0(w0),
		.w1(w1),
		.fifo_rd(fifo_rd),
		.w_load(w_load),
		.w_index(w_index),
		.w_word(w_word),
		.w_zero_fill(w_zero_fill),
		.w_pad(w_pad),
		.pad_pos(pad_pos),
		.w_length(w_length),
		.length_bits(length_bits),
		.w_step(w_step),
		.extend(extend),
		.hash_valid(hash_valid),
		.hash(hash)
	);

endmodule

/* tb_streaming_sha256.sv */
`timescale 1ns/1ps

module tb_streaming_sha256;

	localparam int TIMEOUT_CYCLES = 400;

	////////////////////
	// Published FIPS 180-4 vectors

	localparam sha256_pkg::sha256_digest_t DIGEST_EMPTY =
		256'he3b0c44298fc1c149afbf4c8996fb92427ae41e4649b934ca495991b7852b855;
	localparam sha256_pkg::sha256_digest_t DIGEST_ABC =
		256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad;
	localparam sha256_pkg::sha256_digest_t DIGEST_56 =
		256'h248d6a61d20638b8e5c026930c3e6039a33ce45964ff2167f6ecedd419db06c1;
	// 56 bytes, so the length spills into a second block
	localparam string MSG_56 = "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq";

	logic clk;
	logic reset;
	logic start;
	logic update;
	sha256_pkg::sha256_word_t data_in;
	logic [2:0] bytes_valid;
	logic finalize;
	logic hash_valid;
	sha256_pkg::sha256_digest_t hash;

	integer seed;
	int errors;
	int test_err_start;
	int tests_run;
	int tests_failed;
	// Bytes of the message being sent, first byte at index 0
	logic [7:0] msg_q[$];

	streaming_sha256 #(
		.FIFO_DEPTH(128)
	) dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.update(update),
		.data_in(data_in),
		.bytes_valid(bytes_valid),
		.finalize(finalize),
		.hash_valid(hash_valid),
		.hash(hash)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Checks

	task automatic compare_digest(input string name, input sha256_pkg::sha256_digest_t got,
		input sha256_pkg::sha256_digest_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Check errors plus failed assertions in the bound checker
	function automatic int error_total();
		return errors + dut.props.assert_fails;
	endfunction

	////////////////////
	// Stimulus

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic load_message(input string s);
		msg_q.delete();
		for (int i = 0; i < s.len(); i++) begin
			msg_q.push_back(s[i]);
		end
	endtask

	// Words of 4 bytes, or random chunks of 1 to 4, then finalize
	task automatic send_message(input bit random_chunks);
		int idx;
		int n;
		sha256_pkg::sha256_word_t word;
		idx = 0;
		while (idx < msg_q.size()) begin
			if (random_chunks) begin
				n = (($random(seed) & 32'h7fffffff) % 4) + 1;
			end else begin
				n = 4;
			end
			if (n > msg_q.size() - idx) begin
				n = msg_q.size() - idx;
			end
			// Valid bytes left-justified, first byte at the top
			word = '0;
			for (int k = 0; k < n; k++) begin
				word[31 - 8*k -: 8] = msg_q[idx + k];
			end
			@(posedge clk);
			update <= 1'b1;
			data_in <= word;
			bytes_valid <= 3'(n);
			idx += n;
		end
		@(posedge clk);
		update <= 1'b0;
		data_in <= '0;
		bytes_valid <= 3'd0;
		// One idle cycle before the flush
		@(posedge clk);
		finalize <= 1'b1;
		@(posedge clk);
		finalize <= 1'b0;
	endtask

	// Sampled on the falling edge, where DUT outputs are settled
	task automatic wait_digest(input string name, output bit got);
		int cycles;
		got = 1'b0;
		cycles = 0;
		while (!got && (cycles < TIMEOUT_CYCLES)) begin
			@(negedge clk);
			if (hash_valid === 1'b1) begin
				got = 1'b1;
			end
			cycles++;
		end
		if (!got) begin
			errors++;
			$display("No digest arrived within %0d cycles in test %s", TIMEOUT_CYCLES, name);
		end
	endtask

	// No digest strobe and a cleared hash for a number of cycles
	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			compare_bit("hash_valid", hash_valid, 1'b0);
			compare_digest("hash", hash, '0);
		end
	endtask

	task automatic hash_message(input string name, input string s, input bit random_chunks,
		input sha256_pkg::sha256_digest_t exp);
		bit got;
		pulse_start();
		load_message(s);
		send_message(random_chunks);
		wait_digest(name, got);
		if (got) begin
			compare_digest("hash", hash, exp);
		end
	endtask

	////////////////////
	// Per-test bookkeeping

	task automatic begin_test();
		test_err_start = error_total();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (error_total() != test_err_start) begin
			tests_failed++;
			$display("Test %s: failed", name);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	////////////////////
	// Tests

	task automatic test_reset_state();
		begin_test();
		expect_quiet(10);
		end_test("reset state");
	endtask

	task automatic test_back_to_back_and_reset();
		begin_test();
		// Second start lands in the cycle after the first strobe
		hash_message("back to back 1", "abc", 1'b0, DIGEST_ABC);
		hash_message("back to back 2", "", 1'b0, DIGEST_EMPTY);
		// Third hash cut off by reset while its first block runs
		pulse_start();
		load_message(MSG_56);
		send_message(1'b0);
		repeat (20) @(posedge clk);
		reset <= 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// Window outlasts the remaining two-block latency of the cut-off hash
		expect_quiet(200);
		hash_message("after reset", "abc", 1'b0, DIGEST_ABC);
		end_test("back to back and reset");
	endtask

	initial begin
		seed = 51;
		errors = 0;
		test_err_start = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b1;
		start = 1'b0;
		update = 1'b0;
		data_in = '0;
		bytes_valid = 3'd0;
		finalize = 1'b0;

		apply_reset();

		test_reset_state();

		begin_test();
		hash_message("empty", "", 1'b0, DIGEST_EMPTY);
		end_test("empty message");

		begin_test();
		hash_message("abc", "abc", 1'b0, DIGEST_ABC);
		end_test("abc partial word");

		begin_test();
		hash_message("56 bytes", MSG_56, 1'b0, DIGEST_56);
		end_test("56 bytes two blocks");

		begin_test();
		hash_message("56 bytes chunked", MSG_56, 1'b1, DIGEST_56);
		end_test("56 bytes random chunks");

		test_back_to_back_and_reset();

		$display("Tests run: %0d, tests failed: %0d, check errors: %0d, assertion failures: %0d",
			tests_run, tests_failed, errors, dut.props.assert_fails);
		if (error_total() == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
